// File: source/bitpack_cfg_pkg.sv
package bitpack_cfg_pkg;

   // output word width
   localparam int WORD_W = 32;

   // widest code accepted from the producer
   localparam int CODE_MAX_W = 16;

   // code length field, holds 0 to 16
   localparam int LEN_W = 5;

   // one full word plus one widest code
   localparam int REG_W = WORD_W + CODE_MAX_W;

   // fifo level, covers 0 to REG_W
   localparam int LVL_W = 7;

   // words per stream
   localparam int CNT_W = 16;

endpackage

// File: source/bitpack_types_pkg.sv
package bitpack_types_pkg;

   import bitpack_cfg_pkg::*;

   // producer code, valid bits sit at the msb end of bits
   typedef struct packed {
      logic [LEN_W-1:0]      len;
      logic [CODE_MAX_W-1:0] bits;
   } code_t;

   // packed output word
   typedef struct packed {
      logic [WORD_W-1:0] data;
      logic              last;
   } word_t;

   // controller command to the bit fifo
   // write wins when both strobes are set
   typedef struct packed {
      logic             write;
      logic [LEN_W-1:0] wlen;
      logic             read;
      logic [LVL_W-1:0] rlen;
   } fifo_ctl_t;

endpackage

// File: source/bit_fifo.sv
`timescale 1ns/1ps

module bit_fifo
   import bitpack_cfg_pkg::*, bitpack_types_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  fifo_ctl_t             ctl_i,
   input  logic [CODE_MAX_W-1:0] code_bits_i,
   output logic [WORD_W-1:0]     rdata_o,
   output logic [LVL_W-1:0]      rlevel_o
);

   // bit store with the oldest bit at the msb
   logic [REG_W-1:0] data_q;
   logic [REG_W-1:0] data_d;

   // number of valid bits in data_q
   logic [LVL_W-1:0] level_q;
   logic [LVL_W-1:0] level_d;

   // keeps only the wlen leading bits of the incoming code
   logic [CODE_MAX_W-1:0] code_mask;

   // incoming code moved to just below the current level
   logic [REG_W-1:0] merge_bits;

   // keeps only the rlen leading bits of the read word
   logic [WORD_W-1:0] rd_mask;

   assign code_mask  = ~({CODE_MAX_W{1'b1}} >> ctl_i.wlen);
   assign merge_bits = {code_bits_i & code_mask, {WORD_W{1'b0}}} >> level_q;

   // bits past the level are always zero so the or below is a clean append
   assign rd_mask = ~({WORD_W{1'b1}} >> ctl_i.rlen);
   assign rdata_o = data_q[REG_W-1 -: WORD_W] & rd_mask;

   assign rlevel_o = level_q;

   always_comb begin
      data_d  = data_q;
      level_d = level_q;
      if (ctl_i.write) begin
         data_d  = data_q | merge_bits;
         level_d = level_q + LVL_W'(ctl_i.wlen);
      end else if (ctl_i.read) begin
         // drop the bits just read and shift zeros in from the bottom
         data_d  = data_q << ctl_i.rlen;
         level_d = level_q - ctl_i.rlen;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_q  <= '0;
         level_q <= '0;
      end else begin
         data_q  <= data_d;
         level_q <= level_d;
      end
   end

   // the controller must never overfill the register
   a_wr_in_range : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      ctl_i.write |=> (level_q <= LVL_W'(REG_W))
   ) else $error("bit_fifo: write took level past %0d", REG_W);

   // a read only takes bits that were written before
   a_rd_le_level : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (ctl_i.read && !ctl_i.write) |-> (ctl_i.rlen <= level_q)
   ) else $error("bit_fifo: read of %0d bits with level %0d", ctl_i.rlen, level_q);

   // one read never spans more than a word
   a_rd_le_word : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      ctl_i.read |-> (ctl_i.rlen <= LVL_W'(WORD_W))
   ) else $error("bit_fifo: read length %0d above word width", ctl_i.rlen);

endmodule

// File: source/pack_ctrl.sv
`timescale 1ns/1ps

module pack_ctrl
   import bitpack_cfg_pkg::*, bitpack_types_pkg::*;
(
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             code_valid_i,
   input  logic             flush_i,
   input  logic [LEN_W-1:0] code_len_i,
   input  logic [LVL_W-1:0] rlevel_i,
   output logic             accept_o,
   output fifo_ctl_t        fifo_ctl_o,
   output logic             word_read_o,
   output logic             last_o,
   output logic             done_o
);

   typedef enum logic [1:0] {
      RUN   = 2'd0,
      FLUSH = 2'd1,
      DONE  = 2'd2
   } state_t;

   state_t state_q;
   state_t state_d;

   // a code is written on this edge
   logic take_code;

   // flush request taken on this edge
   logic take_flush;

   // below a full word the fifo has room for one more code
   assign accept_o   = (state_q == RUN) && (rlevel_i < LVL_W'(WORD_W));
   assign take_code  = accept_o && code_valid_i;
   assign take_flush = accept_o && flush_i;
   assign done_o     = (state_q == DONE);

   always_comb begin
      state_d     = state_q;
      fifo_ctl_o  = '0;
      word_read_o = 1'b0;
      last_o      = 1'b0;
      case (state_q)
         RUN: begin
            if (take_code) begin
               fifo_ctl_o.write = 1'b1;
               fifo_ctl_o.wlen  = code_len_i;
            end else if (take_flush) begin
               state_d = FLUSH;
            end else if (!accept_o) begin
               // a full word is waiting
               fifo_ctl_o.read = 1'b1;
               fifo_ctl_o.rlen = LVL_W'(WORD_W);
               word_read_o     = 1'b1;
            end
         end
         FLUSH: begin
            // level is below a word here so one read empties the fifo
            if (rlevel_i != '0) begin
               fifo_ctl_o.read = 1'b1;
               fifo_ctl_o.rlen = rlevel_i;
               word_read_o     = 1'b1;
               last_o          = 1'b1;
            end
            state_d = DONE;
         end
         DONE: begin
            state_d = RUN;
         end
         default: begin
            state_d = RUN;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= RUN;
      end else begin
         state_q <= state_d;
      end
   end

   a_state_legal : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      state_q inside {RUN, FLUSH, DONE}
   ) else $error("pack_ctrl: illegal state %0d", state_q);

   a_code_len : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      take_code |-> (code_len_i >= LEN_W'(1)) && (code_len_i <= LEN_W'(CODE_MAX_W))
   ) else $error("pack_ctrl: code length %0d out of range", code_len_i);

endmodule

// File: source/word_counter.sv
`timescale 1ns/1ps

module word_counter
   import bitpack_cfg_pkg::*;
(
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             word_read_i,
   input  logic             done_i,
   output logic [CNT_W-1:0] count_o
);

   // words read so far in the current stream
   logic [CNT_W-1:0] run_cnt_q;

   // total of the last finished stream
   logic [CNT_W-1:0] total_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         run_cnt_q <= '0;
         total_q   <= '0;
      end else if (done_i) begin
         total_q   <= run_cnt_q;
         run_cnt_q <= '0;
      end else if (word_read_i) begin
         run_cnt_q <= run_cnt_q + 1'b1;
      end
   end

   // running count is already final while done is high
   assign count_o = done_i ? run_cnt_q : total_q;

   a_no_wrap : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (word_read_i && !done_i) |=> (run_cnt_q != '0)
   ) else $error("word_counter: word count wrapped");

endmodule

// File: source/bit_packer_top.sv
`timescale 1ns/1ps

module bit_packer_top
   import bitpack_cfg_pkg::*, bitpack_types_pkg::*;
(
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             code_valid_i,
   input  logic             flush_i,
   input  code_t            code_i,
   output logic             accept_o,
   output word_t            word_o,
   output logic             word_valid_o,
   output logic             done_o,
   output logic [CNT_W-1:0] word_count_o
);

   fifo_ctl_t         fifo_ctl;
   logic [LVL_W-1:0]  rlevel;
   logic [WORD_W-1:0] rdata;
   logic              word_read;
   logic              last;

   // output word register
   word_t word_q;
   logic  word_valid_q;

   pack_ctrl u_pack_ctrl (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .code_valid_i(code_valid_i),
      .flush_i     (flush_i),
      .code_len_i  (code_i.len),
      .rlevel_i    (rlevel),
      .accept_o    (accept_o),
      .fifo_ctl_o  (fifo_ctl),
      .word_read_o (word_read),
      .last_o      (last),
      .done_o      (done_o)
   );

   bit_fifo u_bit_fifo (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .ctl_i      (fifo_ctl),
      .code_bits_i(code_i.bits),
      .rdata_o    (rdata),
      .rlevel_o   (rlevel)
   );

   word_counter u_word_counter (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .word_read_i(word_read),
      .done_i     (done_o),
      .count_o    (word_count_o)
   );

   // read data is combinational and is captured on the read edge
   always_ff @(posedge clk_i) begin
      if (word_read) begin
         word_q.data <= rdata;
         word_q.last <= last;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         word_valid_q <= 1'b0;
      end else begin
         word_valid_q <= word_read;
      end
   end

   assign word_o       = word_q;
   assign word_valid_o = word_valid_q;

endmodule

// File: test/bit_packer_tb.sv
`timescale 1ns/1ps

module bit_packer_tb
   import bitpack_cfg_pkg::*, bitpack_types_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   localparam int SEED         = 7935;
   localparam int DONE_WAIT    = 8;

   // codes per test
   localparam int RAND_CODES    = 48;
   localparam int LONG_RUN      = 24;
   localparam int SHORT_RUN     = 64;
   localparam int ALT_PAIRS     = 24;
   localparam int PARTIAL_CODES = 20;
   localparam int ZERO_CODES    = 12;
   localparam int MIXED_CODES   = 96;
   localparam int TOTAL_CODES   = RAND_CODES + LONG_RUN + SHORT_RUN + 2 * ALT_PAIRS
                                  + PARTIAL_CODES + 1 + ZERO_CODES + 2 + MIXED_CODES;
   localparam int TIMEOUT_CYCLES = TOTAL_CODES * 4 + 300;

   // model phases
   localparam int PH_RUN   = 0;
   localparam int PH_FLUSH = 1;
   localparam int PH_DONE  = 2;

   logic             clk_i;
   logic             arst_n_i;
   logic             code_valid_i;
   logic             flush_i;
   code_t            code_i;
   logic             accept_o;
   word_t            word_o;
   logic             word_valid_o;
   logic             done_o;
   logic [CNT_W-1:0] word_count_o;

   // reference model holding bits in the order they were accepted
   logic              bit_q[$];
   int                mdl_level;
   int                mdl_phase;
   logic              mdl_accept;
   logic              exp_valid;
   logic [WORD_W-1:0] exp_data;
   logic              exp_last;
   logic              exp_done;
   logic [CNT_W-1:0]  stream_words;
   logic [CNT_W-1:0]  total_words;
   logic [CNT_W-1:0]  exp_count;

   int err_cnt       = 0;
   int test_idx      = 0;
   int test_err_base = 0;
   int pass_cnt      = 0;
   int fail_cnt      = 0;
   int sent_bits     = 0;

   bit_packer_top UUT (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .code_valid_i(code_valid_i),
      .flush_i     (flush_i),
      .code_i      (code_i),
      .accept_o    (accept_o),
      .word_o      (word_o),
      .word_valid_o(word_valid_o),
      .done_o      (done_o),
      .word_count_o(word_count_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // removes the n oldest bits msb first with zeros below
   function automatic logic [WORD_W-1:0] take_front_bits(input int n);
      logic [WORD_W-1:0] w;
      w = '0;
      for (int i = 0; i < n; i++) begin
         w[WORD_W-1-i] = bit_q.pop_front();
      end
      return w;
   endfunction

   assign mdl_accept = (mdl_phase == PH_RUN) && (mdl_level < WORD_W);
   assign exp_done   = (mdl_phase == PH_DONE);
   assign exp_count  = exp_done ? stream_words : total_words;

   always @(posedge clk_i or negedge arst_n_i) begin : model
      logic [WORD_W-1:0] w;
      if (!arst_n_i) begin
         bit_q.delete();
         mdl_level    <= 0;
         mdl_phase    <= PH_RUN;
         exp_valid    <= 1'b0;
         exp_data     <= '0;
         exp_last     <= 1'b0;
         stream_words <= '0;
         total_words  <= '0;
      end else begin
         exp_valid <= 1'b0;
         case (mdl_phase)
            PH_RUN: begin
               if (code_valid_i && mdl_accept) begin
                  for (int i = 0; i < int'(code_i.len); i++) begin
                     bit_q.push_back(code_i.bits[CODE_MAX_W-1-i]);
                  end
                  mdl_level <= mdl_level + int'(code_i.len);
               end else if (flush_i && mdl_accept) begin
                  mdl_phase <= PH_FLUSH;
               end else if (!mdl_accept) begin
                  w = take_front_bits(WORD_W);
                  exp_data     <= w;
                  exp_last     <= 1'b0;
                  exp_valid    <= 1'b1;
                  mdl_level    <= mdl_level - WORD_W;
                  stream_words <= stream_words + 1'b1;
               end
            end
            PH_FLUSH: begin
               // padded final word only when bits are left
               if (mdl_level > 0) begin
                  w = take_front_bits(mdl_level);
                  exp_data     <= w;
                  exp_last     <= 1'b1;
                  exp_valid    <= 1'b1;
                  mdl_level    <= 0;
                  stream_words <= stream_words + 1'b1;
               end
               mdl_phase <= PH_DONE;
            end
            default: begin
               total_words  <= stream_words;
               stream_words <= '0;
               mdl_phase    <= PH_RUN;
            end
         endcase
      end
   end

   a_reset_state : assert property (
      @(posedge clk_i)
      !arst_n_i |-> (!word_valid_o && !done_o && accept_o && word_count_o == '0)
   ) else begin
      err_cnt++;
      $display("MISMATCH {word_valid_o,done_o,accept_o,word_count_o}: got 0x%0h expected 0x%0h",
               $sampled({word_valid_o, done_o, accept_o, word_count_o}), {3'b001, 16'h0});
   end

   a_accept : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      accept_o == mdl_accept
   ) else begin
      err_cnt++;
      $display("MISMATCH accept_o: got 0x%0h expected 0x%0h",
               $sampled(accept_o), $sampled(mdl_accept));
   end

   a_word_valid : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      word_valid_o == exp_valid
   ) else begin
      err_cnt++;
      $display("MISMATCH word_valid_o: got 0x%0h expected 0x%0h",
               $sampled(word_valid_o), $sampled(exp_valid));
   end

   a_word_data : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      exp_valid |-> (word_o.data == exp_data)
   ) else begin
      err_cnt++;
      $display("MISMATCH word_o.data: got 0x%08h expected 0x%08h",
               $sampled(word_o.data), $sampled(exp_data));
   end

   a_word_last : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      exp_valid |-> (word_o.last == exp_last)
   ) else begin
      err_cnt++;
      $display("MISMATCH word_o.last: got 0x%0h expected 0x%0h",
               $sampled(word_o.last), $sampled(exp_last));
   end

   a_done : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      done_o == exp_done
   ) else begin
      err_cnt++;
      $display("MISMATCH done_o: got 0x%0h expected 0x%0h",
               $sampled(done_o), $sampled(exp_done));
   end

   a_count : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      word_count_o == exp_count
   ) else begin
      err_cnt++;
      $display("MISMATCH word_count_o: got 0x%04h expected 0x%04h",
               $sampled(word_count_o), $sampled(exp_count));
   end

   // returns on the negedge before the edge that takes the code
   task automatic send_code(input int len);
      code_t c;
      c.len  = LEN_W'(len);
      c.bits = CODE_MAX_W'($urandom);
      @(posedge clk_i);
      code_valid_i <= 1'b1;
      flush_i      <= 1'b0;
      code_i       <= c;
      @(negedge clk_i);
      while (!accept_o) begin
         @(negedge clk_i);
      end
      sent_bits += len;
   endtask

   task automatic request_flush();
      int waited;
      waited = 0;
      @(posedge clk_i);
      code_valid_i <= 1'b0;
      flush_i      <= 1'b1;
      @(negedge clk_i);
      while (!accept_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      flush_i <= 1'b0;
      @(negedge clk_i);
      while (!done_o && waited < DONE_WAIT) begin
         waited++;
         @(negedge clk_i);
      end
      if (!done_o) begin
         err_cnt++;
         $display("done_o did not pulse within %0d cycles after a flush", DONE_WAIT);
      end
      sent_bits = 0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         code_valid_i <= 1'b0;
         flush_i      <= 1'b0;
      end
   endtask

   // tops the stream up to a whole number of words
   task automatic fill_to_word();
      int len;
      while (sent_bits % WORD_W != 0) begin
         len = WORD_W - sent_bits % WORD_W;
         if (len > CODE_MAX_W) begin
            len = CODE_MAX_W;
         end
         send_code(len);
      end
   endtask

   task automatic start_test();
      test_err_base = err_cnt;
   endtask

   task automatic finish_test(input string name);
      test_idx++;
      if (err_cnt == test_err_base) begin
         pass_cnt++;
         $display("test %0d %s: ok", test_idx, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: %0d errors", test_idx, name, err_cnt - test_err_base);
      end
   endtask

   initial begin : stimulus
      int pick;
      arst_n_i     = 1'b0;
      code_valid_i = 1'b0;
      flush_i      = 1'b0;
      code_i       = '0;
      void'($urandom(SEED));

      start_test();
      repeat (RESET_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;
      idle_cycles(2);
      finish_test("reset state");

      start_test();
      repeat (RAND_CODES) begin
         send_code($urandom_range(CODE_MAX_W, 1));
         if ($urandom_range(3) == 0) begin
            idle_cycles(1);
         end
      end
      idle_cycles(2);
      finish_test("full words");

      // long and short runs cross word edges at every offset
      start_test();
      repeat (LONG_RUN) send_code(CODE_MAX_W);
      repeat (SHORT_RUN) send_code(1);
      repeat (ALT_PAIRS) begin
         send_code(CODE_MAX_W);
         send_code(1);
      end
      idle_cycles(2);
      finish_test("word boundaries");

      start_test();
      repeat (PARTIAL_CODES) send_code($urandom_range(CODE_MAX_W, 1));
      if (sent_bits % WORD_W == 0) begin
         send_code(3);
      end
      request_flush();
      finish_test("partial flush");

      // second flush closes an empty stream
      start_test();
      repeat (ZERO_CODES) send_code($urandom_range(CODE_MAX_W, 1));
      fill_to_word();
      request_flush();
      request_flush();
      finish_test("empty flush");

      start_test();
      repeat (MIXED_CODES) begin
         pick = $urandom_range(11);
         if (pick == 0) begin
            request_flush();
         end else if (pick == 1) begin
            idle_cycles($urandom_range(3, 1));
         end else begin
            send_code($urandom_range(CODE_MAX_W, 1));
         end
      end
      request_flush();
      idle_cycles(4);
      finish_test("accept level");

      $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: compile.f
source/bitpack_cfg_pkg.sv
source/bitpack_types_pkg.sv
source/bit_fifo.sv
source/pack_ctrl.sv
source/word_counter.sv
source/bit_packer_top.sv
test/bit_packer_tb.sv

// File: Makefile
# Verilator build and run for the bit packer testbench

VERILATOR ?= verilator
TOP       ?= bit_packer_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := TEST RESULT: PASS
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
